// File: common/dot11_rx_config.svh
`ifndef DOT11_RX_CONFIG_SVH
`define DOT11_RX_CONFIG_SVH

// byte stream and header word widths
`define DOT11_BYTE_W 8
`define DOT11_SIG_W 24
`define DOT11_LEN_W 16

// CRC-32 register value left by a frame with a correct FCS
`define DOT11_FCS_RESIDUE 32'hc704dd7b

// legacy rate code that carries an HT packet
`define DOT11_HT_CARRIER_RATE 4'b1011

// highest supported HT MCS
`define DOT11_HT_MAX_MCS 7

// HT-SIG1 bits 0..23 plus HT-SIG2 bits 0..9
`define DOT11_HT_CRC_BITS 34

`endif

// File: common/dot11_rx_pkg.sv
`default_nettype none

`include "dot11_rx_config.svh"

package dot11_rx_pkg;

    //////////////////////////////////////////////////
    // byte stream
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                     stb;
        logic [`DOT11_BYTE_W-1:0] data;
    } rx_byte_t;

    //////////////////////////////////////////////////
    // collected header words
    //////////////////////////////////////////////////

    // each word filled lsb byte first
    typedef struct packed {
        logic                    stb;
        logic                    is_ht;
        logic [`DOT11_SIG_W-1:0] sig;
        logic [`DOT11_SIG_W-1:0] ht_sig1;
        logic [`DOT11_SIG_W-1:0] ht_sig2;
    } sig_fields_t;

    //////////////////////////////////////////////////
    // status codes
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        E_OK                  = 4'd0,
        E_PARITY_FAIL         = 4'd1,
        E_WRONG_RSVD          = 4'd2,
        E_WRONG_TAIL          = 4'd3,
        E_UNSUPPORTED_RATE    = 4'd4,
        E_WRONG_CRC           = 4'd5,
        E_UNSUPPORTED_MCS     = 4'd6,
        E_UNSUPPORTED_CBW     = 4'd7,
        E_HT_WRONG_RSVD       = 4'd8,
        E_UNSUPPORTED_STBC    = 4'd9,
        E_UNSUPPORTED_FEC     = 4'd10,
        E_UNSUPPORTED_SPATIAL = 4'd11,
        E_HT_WRONG_TAIL       = 4'd12,
        E_WRONG_FCS           = 4'd13
    } status_e;

    //////////////////////////////////////////////////
    // verdicts
    //////////////////////////////////////////////////

    // rate bit 7 marks HT, low bits hold MCS or legacy rate
    typedef struct packed {
        logic                    stb;
        logic                    valid;
        logic                    ht;
        logic [7:0]              rate;
        logic [`DOT11_LEN_W-1:0] len;
        status_e                 status;
    } header_result_t;

    typedef struct packed {
        logic    stb;
        logic    ok;
        status_e status;
    } fcs_result_t;

endpackage

`default_nettype wire

// File: sig_header/sig_field_collector.sv
`default_nettype none

`include "dot11_rx_config.svh"

module sig_field_collector (
    input  wire logic                    clock,
    input  wire logic                    equalizer_reset,
    input  wire logic                    start_i,
    input  wire dot11_rx_pkg::rx_byte_t  byte_i,
    input  wire logic                    ht_mode_i,
    output dot11_rx_pkg::sig_fields_t    fields_o,
    output dot11_rx_pkg::rx_byte_t       payload_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LEGACY,
        S_HT,
        S_PAYLOAD
    } state_t;

    state_t                   state_q;
    logic [2:0]               count_q;
    logic                     is_ht_q;
    logic                     fields_stb_q;
    logic                     payload_stb_q;
    logic [`DOT11_SIG_W-1:0]  sig_q;
    logic [`DOT11_SIG_W-1:0]  ht_sig1_q;
    logic [`DOT11_SIG_W-1:0]  ht_sig2_q;
    logic [`DOT11_BYTE_W-1:0] payload_data_q;

    //////////////////////////////////////////////////
    // header byte counter
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state_q       <= S_IDLE;
            count_q       <= '0;
            is_ht_q       <= 1'b0;
            fields_stb_q  <= 1'b0;
            payload_stb_q <= 1'b0;
        end else begin
            fields_stb_q  <= 1'b0;
            payload_stb_q <= 1'b0;
            if (start_i) begin
                state_q <= S_LEGACY;
                count_q <= '0;
                is_ht_q <= 1'b0;
            end else if (byte_i.stb) begin
                case (state_q)
                    S_LEGACY: begin
                        if (count_q == 3'd2) begin
                            // third byte decides on 3 or 9 header bytes
                            count_q <= '0;
                            is_ht_q <= ht_mode_i;
                            if (ht_mode_i) begin
                                state_q <= S_HT;
                            end else begin
                                state_q      <= S_PAYLOAD;
                                fields_stb_q <= 1'b1;
                            end
                        end else begin
                            count_q <= count_q + 3'd1;
                        end
                    end
                    S_HT: begin
                        if (count_q == 3'd5) begin
                            state_q      <= S_PAYLOAD;
                            fields_stb_q <= 1'b1;
                        end else begin
                            count_q <= count_q + 3'd1;
                        end
                    end
                    S_PAYLOAD: payload_stb_q <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // word shifters, new byte enters at the top
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (byte_i.stb) begin
            if (state_q == S_LEGACY) begin
                sig_q <= {byte_i.data, sig_q[`DOT11_SIG_W-1:`DOT11_BYTE_W]};
            end
            if (state_q == S_HT && count_q < 3'd3) begin
                ht_sig1_q <= {byte_i.data, ht_sig1_q[`DOT11_SIG_W-1:`DOT11_BYTE_W]};
            end
            if (state_q == S_HT && count_q >= 3'd3) begin
                ht_sig2_q <= {byte_i.data, ht_sig2_q[`DOT11_SIG_W-1:`DOT11_BYTE_W]};
            end
            payload_data_q <= byte_i.data;
        end
    end

    assign fields_o = '{stb: fields_stb_q, is_ht: is_ht_q, sig: sig_q,
                        ht_sig1: ht_sig1_q, ht_sig2: ht_sig2_q};
    assign payload_o = '{stb: payload_stb_q, data: payload_data_q};

    // front end spaces its byte strobes
    a_byte_spacing: assert property (@(posedge clock) disable iff (equalizer_reset)
        byte_i.stb |=> !byte_i.stb);

endmodule

`default_nettype wire

// File: sig_header/header_check.sv
`default_nettype none

`include "dot11_rx_config.svh"

module header_check (
    input  wire logic                       clock,
    input  wire logic                       equalizer_reset,
    input  wire logic                       start_i,
    input  wire dot11_rx_pkg::sig_fields_t  fields_i,
    input  wire dot11_rx_pkg::rx_byte_t     payload_i,
    output dot11_rx_pkg::header_result_t    header_o,
    output dot11_rx_pkg::rx_byte_t          payload_o
);

    // CRC-8 x^8+x^2+x+1, all ones preset, inverted, c7 lands in field bit 0
    function automatic logic [7:0] ht_crc8(input logic [`DOT11_HT_CRC_BITS-1:0] bits);
        logic [7:0] c;
        logic [7:0] crc;
        logic       fb;
        c = 8'hff;
        for (int i = 0; i < `DOT11_HT_CRC_BITS; i++) begin
            fb = bits[i] ^ c[7];
            c  = {c[6:2], c[1] ^ fb, c[0] ^ fb, fb};
        end
        for (int i = 0; i < 8; i++) begin
            crc[i] = ~c[7-i];
        end
        return crc;
    endfunction

    logic [`DOT11_SIG_W-1:0] sig;
    logic [`DOT11_SIG_W-1:0] sig1;
    logic [`DOT11_SIG_W-1:0] sig2;
    logic [7:0]              crc_calc;
    dot11_rx_pkg::status_e   chk_status;

    logic                    hdr_stb_q;
    logic                    hdr_valid_q;
    logic                    hdr_ht_q;
    logic [7:0]              hdr_rate_q;
    logic [`DOT11_LEN_W-1:0] hdr_len_q;
    dot11_rx_pkg::status_e   hdr_status_q;
    logic                    pass_q;
    logic                    fwd_stb_q;
    logic [`DOT11_BYTE_W-1:0] fwd_data_q;

    assign sig      = fields_i.sig;
    assign sig1     = fields_i.ht_sig1;
    assign sig2     = fields_i.ht_sig2;
    assign crc_calc = ht_crc8({sig2[9:0], sig1});

    //////////////////////////////////////////////////
    // checks in priority order
    //////////////////////////////////////////////////

    always_comb begin
        chk_status = dot11_rx_pkg::E_OK;
        if (^sig[17:0]) begin
            chk_status = dot11_rx_pkg::E_PARITY_FAIL;
        end else if (sig[4]) begin
            chk_status = dot11_rx_pkg::E_WRONG_RSVD;
        end else if (|sig[23:18]) begin
            chk_status = dot11_rx_pkg::E_WRONG_TAIL;
        end else if (!sig[3]) begin
            chk_status = dot11_rx_pkg::E_UNSUPPORTED_RATE;
        end else if (fields_i.is_ht) begin
            if (sig[3:0] != `DOT11_HT_CARRIER_RATE) begin
                chk_status = dot11_rx_pkg::E_UNSUPPORTED_RATE;
            end else if (crc_calc != sig2[17:10]) begin
                chk_status = dot11_rx_pkg::E_WRONG_CRC;
            end else if (sig1[6:0] > `DOT11_HT_MAX_MCS) begin
                chk_status = dot11_rx_pkg::E_UNSUPPORTED_MCS;
            end else if (sig1[7]) begin
                chk_status = dot11_rx_pkg::E_UNSUPPORTED_CBW;
            end else if (!sig2[2]) begin
                chk_status = dot11_rx_pkg::E_HT_WRONG_RSVD;
            end else if (sig2[5:4] != 2'd0) begin
                chk_status = dot11_rx_pkg::E_UNSUPPORTED_STBC;
            end else if (sig2[6]) begin
                chk_status = dot11_rx_pkg::E_UNSUPPORTED_FEC;
            end else if (sig2[9:8] != 2'd0) begin
                chk_status = dot11_rx_pkg::E_UNSUPPORTED_SPATIAL;
            end else if (sig2[23:18] != 6'd0) begin
                chk_status = dot11_rx_pkg::E_HT_WRONG_TAIL;
            end
        end
    end

    //////////////////////////////////////////////////
    // verdict and payload gate
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            hdr_stb_q   <= 1'b0;
            hdr_valid_q <= 1'b0;
            pass_q      <= 1'b0;
            fwd_stb_q   <= 1'b0;
        end else begin
            hdr_stb_q <= fields_i.stb;
            fwd_stb_q <= payload_i.stb && pass_q && !start_i;
            if (start_i) begin
                pass_q <= 1'b0;
            end else if (fields_i.stb) begin
                pass_q <= (chk_status == dot11_rx_pkg::E_OK);
            end
            if (fields_i.stb) begin
                hdr_valid_q <= (chk_status == dot11_rx_pkg::E_OK);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fields_i.stb) begin
            hdr_ht_q     <= fields_i.is_ht;
            hdr_status_q <= chk_status;
            // HT takes MCS and 16-bit length from HT-SIG1
            hdr_rate_q   <= fields_i.is_ht ? {1'b1, sig1[6:0]} : {4'd0, sig[3:0]};
            hdr_len_q    <= fields_i.is_ht ? sig1[23:8] : {4'd0, sig[16:5]};
        end
        fwd_data_q <= payload_i.data;
    end

    assign header_o = '{stb: hdr_stb_q, valid: hdr_valid_q, ht: hdr_ht_q,
                        rate: hdr_rate_q, len: hdr_len_q, status: hdr_status_q};
    assign payload_o = '{stb: fwd_stb_q, data: fwd_data_q};

    // header and payload never share a cycle
    a_hdr_vs_payload: assert property (@(posedge clock) disable iff (equalizer_reset)
        !(header_o.stb && payload_o.stb));

endmodule

`default_nettype wire

// File: payload/payload_fcs.sv
`default_nettype none

`include "dot11_rx_config.svh"

module payload_fcs (
    input  wire logic                          clock,
    input  wire logic                          equalizer_reset,
    input  wire dot11_rx_pkg::header_result_t  header_i,
    input  wire dot11_rx_pkg::rx_byte_t        payload_i,
    output logic                               pkt_begin_o,
    output logic [`DOT11_LEN_W-1:0]            byte_count_o,
    output dot11_rx_pkg::fcs_result_t          fcs_o
);

    // reflected form of the 802.3 polynomial
    localparam logic [31:0] CRC32_POLY = 32'hedb88320;

    // lsb first, one byte per call
    function automatic logic [31:0] crc32_byte(input logic [31:0] c_in,
                                               input logic [`DOT11_BYTE_W-1:0] d);
        logic [31:0] c;
        c = c_in;
        for (int i = 0; i < `DOT11_BYTE_W; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    logic                    active_q;
    logic [`DOT11_LEN_W-1:0] len_q;
    logic [`DOT11_LEN_W-1:0] count_q;
    logic [31:0]             crc_q;
    logic                    begin_q;
    logic                    fcs_stb_q;
    logic                    fcs_ok_q;
    dot11_rx_pkg::status_e   fcs_status_q;

    logic [31:0]             crc_next;
    logic [31:0]             crc_msb;
    logic                    take_byte;
    logic                    last_byte;

    assign crc_next  = crc32_byte(crc_q, payload_i.data);
    // residue is given msb first, so mirror the register
    assign crc_msb   = {<<{crc_next}};
    assign take_byte = active_q && payload_i.stb;
    assign last_byte = take_byte && (count_q + 1'b1 == len_q);

    //////////////////////////////////////////////////
    // length count and verdict
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            active_q     <= 1'b0;
            len_q        <= '0;
            count_q      <= '0;
            begin_q      <= 1'b0;
            fcs_stb_q    <= 1'b0;
            fcs_ok_q     <= 1'b0;
            fcs_status_q <= dot11_rx_pkg::E_OK;
        end else begin
            begin_q   <= header_i.stb && header_i.valid;
            fcs_stb_q <= 1'b0;
            if (header_i.stb) begin
                count_q  <= '0;
                active_q <= header_i.valid && (header_i.len != '0);
                if (header_i.valid) begin
                    len_q <= header_i.len;
                end
                // empty frame has no room for an FCS
                if (header_i.valid && header_i.len == '0) begin
                    fcs_stb_q    <= 1'b1;
                    fcs_ok_q     <= 1'b0;
                    fcs_status_q <= dot11_rx_pkg::E_WRONG_FCS;
                end
            end else if (take_byte) begin
                count_q <= count_q + 1'b1;
                if (last_byte) begin
                    active_q     <= 1'b0;
                    fcs_stb_q    <= 1'b1;
                    fcs_ok_q     <= (crc_msb == `DOT11_FCS_RESIDUE);
                    fcs_status_q <= (crc_msb == `DOT11_FCS_RESIDUE) ?
                                    dot11_rx_pkg::E_OK : dot11_rx_pkg::E_WRONG_FCS;
                end
            end
        end
    end

    // CRC register, preset at each header
    always_ff @(posedge clock) begin
        if (header_i.stb) begin
            crc_q <= '1;
        end else if (take_byte) begin
            crc_q <= crc_next;
        end
    end

    assign pkt_begin_o  = begin_q;
    assign byte_count_o = count_q;
    assign fcs_o        = '{stb: fcs_stb_q, ok: fcs_ok_q, status: fcs_status_q};

    a_count_in_len: assert property (@(posedge clock) disable iff (equalizer_reset)
        byte_count_o <= len_q);

endmodule

`default_nettype wire

// File: hw/dot11_rx_top.sv
`default_nettype none

`include "dot11_rx_config.svh"

module dot11_rx_top (
    input  wire logic                        clock,
    input  wire logic                        equalizer_reset,
    input  wire logic                        start_i,
    input  wire dot11_rx_pkg::rx_byte_t      byte_i,
    input  wire logic                        ht_mode_i,
    output dot11_rx_pkg::header_result_t     header_o,
    output dot11_rx_pkg::rx_byte_t           payload_o,
    output logic                             pkt_begin_o,
    output logic [`DOT11_LEN_W-1:0]          byte_count_o,
    output dot11_rx_pkg::fcs_result_t        fcs_o
);

    dot11_rx_pkg::sig_fields_t fields;
    dot11_rx_pkg::rx_byte_t    raw_payload;

    // stage 1: header bytes into words
    sig_field_collector u_collector (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .start_i         (start_i),
        .byte_i          (byte_i),
        .ht_mode_i       (ht_mode_i),
        .fields_o        (fields),
        .payload_o       (raw_payload)
    );

    // stage 2: header verdict and payload gate
    header_check u_header_check (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .start_i         (start_i),
        .fields_i        (fields),
        .payload_i       (raw_payload),
        .header_o        (header_o),
        .payload_o       (payload_o)
    );

    // stage 3: length count and FCS
    payload_fcs u_payload_fcs (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .header_i        (header_o),
        .payload_i       (payload_o),
        .pkt_begin_o     (pkt_begin_o),
        .byte_count_o    (byte_count_o),
        .fcs_o           (fcs_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clock_o = 1'b0;
        forever #4 clock_o = ~clock_o;
    end

    // reset held for 5 rising edges
    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clock_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/dot11_rx_tb.sv
`default_nettype none

`include "dot11_rx_config.svh"

module dot11_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PACKETS   = 16;
    localparam int MAX_PKT_BYTES = 64;
    localparam int WATCHDOG_NS   = NUM_PACKETS * MAX_PKT_BYTES * 4 * 8 + 2000;
    localparam int STROBE_WAIT   = 20;

    logic                         clock;
    logic                         equalizer_reset;
    logic                         start_i;
    dot11_rx_pkg::rx_byte_t       byte_i;
    logic                         ht_mode_i;
    dot11_rx_pkg::header_result_t header_o;
    dot11_rx_pkg::rx_byte_t       payload_o;
    logic                         pkt_begin_o;
    logic [`DOT11_LEN_W-1:0]      byte_count_o;
    dot11_rx_pkg::fcs_result_t    fcs_o;

    int errors = 0;
    int hdr_seen = 0;
    int fcs_seen = 0;
    int begin_seen = 0;
    int fwd_seen = 0;
    dot11_rx_pkg::header_result_t last_hdr;
    dot11_rx_pkg::fcs_result_t    last_fcs;
    logic [`DOT11_LEN_W-1:0]      count_at_fcs;
    logic [31:0]                  lfsr_q = 32'hb40d_ff0f;
    logic [7:0]                   frame_q[$];
    dot11_rx_pkg::rx_byte_t       fwd_q[$];

    tb_clock_gen u_clock_gen (
        .clock_o (clock),
        .reset_o (equalizer_reset)
    );

    dot11_rx_top uut (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .start_i         (start_i),
        .byte_i          (byte_i),
        .ht_mode_i       (ht_mode_i),
        .header_o        (header_o),
        .payload_o       (payload_o),
        .pkt_begin_o     (pkt_begin_o),
        .byte_count_o    (byte_count_o),
        .fcs_o           (fcs_o)
    );

    // strobe counters and last verdicts
    always @(posedge clock) begin
        if (header_o.stb) begin
            hdr_seen <= hdr_seen + 1;
            last_hdr <= header_o;
        end
        if (fcs_o.stb) begin
            fcs_seen     <= fcs_seen + 1;
            last_fcs     <= fcs_o;
            count_at_fcs <= byte_count_o;
        end
        if (pkt_begin_o) begin
            begin_seen <= begin_seen + 1;
        end
        if (payload_o.stb) begin
            fwd_seen <= fwd_seen + 1;
            fwd_q.push_back(payload_o);
        end
    end

    //////////////////////////////////////////////////
    // reference models
    //////////////////////////////////////////////////

    // Galois form, one step per bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // reflected 802.3 CRC, lsb of each byte first
    function automatic logic [31:0] crc32_model(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] r;
        r = crc ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            r = (r >> 1) ^ (r[0] ? 32'hedb8_8320 : 32'd0);
        end
        return r;
    endfunction

    // random payload, then inverted CRC lsb byte first
    task automatic build_frame(input int n);
        logic [31:0] crc;
        logic [7:0]  b;
        frame_q.delete();
        crc = '1;
        for (int i = 0; i < n; i++) begin
            rand_byte(b);
            frame_q.push_back(b);
            crc = crc32_model(crc, b);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            frame_q.push_back(crc[8*k +: 8]);
        end
    endtask

    // x^8+x^2+x+1 over the 34 covered bits
    function automatic logic [7:0] crc8_field(input logic [`DOT11_HT_CRC_BITS-1:0] bits);
        logic [7:0] r;
        logic [7:0] f;
        logic       fb;
        r = 8'hff;
        for (int i = 0; i < `DOT11_HT_CRC_BITS; i++) begin
            fb = r[7] ^ bits[i];
            r  = {r[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        // c7 goes out first, into the lowest field bit
        for (int k = 0; k < 8; k++) begin
            f[k] = ~r[7-k];
        end
        return f;
    endfunction

    function automatic logic [23:0] legacy_sig(input logic [3:0] rate, input logic [11:0] len,
                                               input logic rsvd, input logic [5:0] tail,
                                               input logic bad_parity);
        logic [16:0] low;
        low = {len, rsvd, rate};
        return {tail, (^low) ^ bad_parity, low};
    endfunction

    function automatic logic [23:0] ht_sig1(input logic [6:0] mcs, input logic [15:0] len);
        return {len, 1'b0, mcs};
    endfunction

    // reserved bit 2 set, stbc in 5:4, crc in 17:10
    function automatic logic [23:0] ht_sig2(input logic [23:0] sig1, input logic [1:0] stbc,
                                            input logic [7:0] crc_flip);
        logic [9:0] low;
        low = {4'd0, stbc, 4'b0100};
        return {6'd0, crc8_field({low, sig1}) ^ crc_flip, low};
    endfunction

    function automatic dot11_rx_pkg::header_result_t expect_header(
            input logic valid, input logic ht, input logic [7:0] rate,
            input logic [15:0] len, input dot11_rx_pkg::status_e status);
        dot11_rx_pkg::header_result_t h;
        h = '{stb: 1'b1, valid: valid, ht: ht, rate: rate, len: len, status: status};
        return h;
    endfunction

    function automatic dot11_rx_pkg::fcs_result_t expect_fcs(input logic ok,
                                                             input dot11_rx_pkg::status_e status);
        dot11_rx_pkg::fcs_result_t f;
        f = '{stb: 1'b1, ok: ok, status: status};
        return f;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_header(input dot11_rx_pkg::header_result_t got,
                                input dot11_rx_pkg::header_result_t exp);
        compare_value("header_o.valid", 32'(got.valid), 32'(exp.valid));
        compare_value("header_o.ht", 32'(got.ht), 32'(exp.ht));
        compare_value("header_o.rate", 32'(got.rate), 32'(exp.rate));
        compare_value("header_o.len", 32'(got.len), 32'(exp.len));
        compare_value("header_o.status", 32'(got.status), 32'(exp.status));
    endtask

    task automatic check_fcs(input dot11_rx_pkg::fcs_result_t got,
                             input dot11_rx_pkg::fcs_result_t exp);
        compare_value("fcs_o.ok", 32'(got.ok), 32'(exp.ok));
        compare_value("fcs_o.status", 32'(got.status), 32'(exp.status));
    endtask

    task automatic check_payload(input dot11_rx_pkg::rx_byte_t got, input logic [7:0] exp);
        compare_value("payload_o.data", 32'(got.data), 32'(exp));
    endtask

    //////////////////////////////////////////////////
    // drivers and bounded waits
    //////////////////////////////////////////////////

    // entered 1 ns after an edge, one byte every 4 cycles
    task automatic send_byte(input logic [7:0] d);
        byte_i = '{stb: 1'b1, data: d};
        @(posedge clock);
        #1;
        byte_i.stb = 1'b0;
        repeat (3) @(posedge clock);
        #1;
    endtask

    task automatic send_word(input logic [23:0] w);
        for (int k = 0; k < 3; k++) begin
            send_byte(w[8*k +: 8]);
        end
    endtask

    task automatic start_packet(input logic ht);
        ht_mode_i = ht;
        start_i   = 1'b1;
        @(posedge clock);
        #1;
        start_i = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic wait_header(input int seen);
        for (int n = 0; n < STROBE_WAIT && hdr_seen == seen; n++) begin
            @(posedge clock);
            #1;
        end
        if (hdr_seen == seen) begin
            errors++;
            $display("%0d ns: no header strobe after the header bytes", $time);
        end
    endtask

    task automatic wait_fcs(input int seen);
        for (int n = 0; n < STROBE_WAIT && fcs_seen == seen; n++) begin
            @(posedge clock);
            #1;
        end
        if (fcs_seen == seen) begin
            errors++;
            $display("%0d ns: no FCS strobe after packet", $time);
        end
    endtask

    // one packet: header, n_send bytes of frame_q, then the verdicts
    task automatic run_packet(input logic ht, input logic [23:0] sig, input logic [23:0] sig1,
                              input logic [23:0] sig2, input int n_send,
                              input dot11_rx_pkg::header_result_t exp_hdr,
                              input logic fcs_due, input dot11_rx_pkg::fcs_result_t exp_fcs);
        int h0;
        int f0;
        int b0;
        int p0;
        h0 = hdr_seen;
        f0 = fcs_seen;
        b0 = begin_seen;
        p0 = fwd_seen;
        fwd_q.delete();
        start_packet(ht);
        send_word(sig);
        if (ht) begin
            send_word(sig1);
            send_word(sig2);
        end
        wait_header(h0);
        if (hdr_seen != h0) begin
            check_header(last_hdr, exp_hdr);
        end
        for (int i = 0; i < n_send; i++) begin
            send_byte(frame_q[i]);
        end
        if (fcs_due) begin
            wait_fcs(f0);
            if (fcs_seen != f0) begin
                check_fcs(last_fcs, exp_fcs);
                compare_value("byte_count_o", 32'(count_at_fcs), frame_q.size());
                compare_value("fcs_o strobes", fcs_seen - f0, 1);
            end
        end else begin
            compare_value("fcs_o strobes", fcs_seen - f0, 0);
        end
        compare_value("pkt_begin_o pulses", begin_seen - b0, exp_hdr.valid ? 1 : 0);
        compare_value("payload_o strobes", fwd_seen - p0, exp_hdr.valid ? n_send : 0);
        for (int i = 0; i < fwd_q.size() && i < n_send; i++) begin
            check_payload(fwd_q[i], frame_q[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_legacy_ok();
        build_frame(40);
        run_packet(1'b0, legacy_sig(4'b1101, 12'd44, 1'b0, 6'd0, 1'b0), '0, '0, 44,
                   expect_header(1'b1, 1'b0, 8'h0d, 16'd44, dot11_rx_pkg::E_OK),
                   1'b1, expect_fcs(1'b1, dot11_rx_pkg::E_OK));
    endtask

    task automatic test_fcs_corrupt();
        build_frame(40);
        // one payload bit flipped after the FCS was computed
        frame_q[7] = frame_q[7] ^ 8'h04;
        run_packet(1'b0, legacy_sig(4'b1101, 12'd44, 1'b0, 6'd0, 1'b0), '0, '0, 44,
                   expect_header(1'b1, 1'b0, 8'h0d, 16'd44, dot11_rx_pkg::E_OK),
                   1'b1, expect_fcs(1'b0, dot11_rx_pkg::E_WRONG_FCS));
    endtask

    task automatic legacy_fault(input logic [23:0] sig, input logic [7:0] rate,
                                input dot11_rx_pkg::status_e status);
        run_packet(1'b0, sig, '0, '0, frame_q.size(),
                   expect_header(1'b0, 1'b0, rate, 16'd44, status),
                   1'b0, expect_fcs(1'b0, dot11_rx_pkg::E_OK));
    endtask

    task automatic test_legacy_faults();
        build_frame(40);
        legacy_fault(legacy_sig(4'b1101, 12'd44, 1'b0, 6'd0, 1'b1), 8'h0d,
                     dot11_rx_pkg::E_PARITY_FAIL);
        legacy_fault(legacy_sig(4'b1101, 12'd44, 1'b1, 6'd0, 1'b0), 8'h0d,
                     dot11_rx_pkg::E_WRONG_RSVD);
        legacy_fault(legacy_sig(4'b1101, 12'd44, 1'b0, 6'b000100, 1'b0), 8'h0d,
                     dot11_rx_pkg::E_WRONG_TAIL);
        legacy_fault(legacy_sig(4'b0101, 12'd44, 1'b0, 6'd0, 1'b0), 8'h05,
                     dot11_rx_pkg::E_UNSUPPORTED_RATE);
    endtask

    task automatic test_ht_ok();
        logic [23:0] s1;
        build_frame(20);
        s1 = ht_sig1(7'd3, 16'd24);
        run_packet(1'b1, legacy_sig(4'b1011, 12'd24, 1'b0, 6'd0, 1'b0), s1,
                   ht_sig2(s1, 2'd0, 8'h00), 24,
                   expect_header(1'b1, 1'b1, 8'h83, 16'd24, dot11_rx_pkg::E_OK),
                   1'b1, expect_fcs(1'b1, dot11_rx_pkg::E_OK));
    endtask

    task automatic ht_fault(input logic [6:0] mcs, input logic [1:0] stbc,
                            input logic [7:0] crc_flip, input dot11_rx_pkg::status_e status);
        logic [23:0] s1;
        s1 = ht_sig1(mcs, 16'd24);
        run_packet(1'b1, legacy_sig(4'b1011, 12'd24, 1'b0, 6'd0, 1'b0), s1,
                   ht_sig2(s1, stbc, crc_flip), frame_q.size(),
                   expect_header(1'b0, 1'b1, {1'b1, mcs}, 16'd24, status),
                   1'b0, expect_fcs(1'b0, dot11_rx_pkg::E_OK));
    endtask

    task automatic test_ht_faults();
        build_frame(20);
        ht_fault(7'd3, 2'd0, 8'h01, dot11_rx_pkg::E_WRONG_CRC);
        ht_fault(7'd9, 2'd0, 8'h00, dot11_rx_pkg::E_UNSUPPORTED_MCS);
        ht_fault(7'd3, 2'd1, 8'h00, dot11_rx_pkg::E_UNSUPPORTED_STBC);
        // several faults, the first in check order wins
        ht_fault(7'd9, 2'd0, 8'h10, dot11_rx_pkg::E_WRONG_CRC);
        ht_fault(7'd9, 2'd1, 8'h00, dot11_rx_pkg::E_UNSUPPORTED_MCS);
    endtask

    task automatic test_restart_mid_payload();
        build_frame(40);
        run_packet(1'b0, legacy_sig(4'b1101, 12'd44, 1'b0, 6'd0, 1'b0), '0, '0, 10,
                   expect_header(1'b1, 1'b0, 8'h0d, 16'd44, dot11_rx_pkg::E_OK),
                   1'b0, expect_fcs(1'b0, dot11_rx_pkg::E_OK));
        test_legacy_ok();
    endtask

    initial begin
        start_i   = 1'b0;
        byte_i    = '0;
        ht_mode_i = 1'b0;
        @(negedge equalizer_reset);
        @(posedge clock);
        #1;
        test_legacy_ok();
        test_fcs_corrupt();
        test_legacy_faults();
        test_ht_ok();
        test_ht_faults();
        test_restart_mid_payload();
        $display("tests done, error count %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // run limit from packet count and length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, error count %0d", WATCHDOG_NS, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/dot11_rx_pkg.sv
sig_header/sig_field_collector.sv
sig_header/header_check.sv
payload/payload_fcs.sv
hw/dot11_rx_top.sv
testbench/tb_clock_gen.sv
testbench/dot11_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dot11 rx back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module dot11_rx_tb -f build.f -o dot11_rx_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/dot11_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
